//--- cpu_alu.sv
`default_nettype none

module cpu_alu import cpu_pkg::*; (
    input  alu_op_t         i_op,
    input  logic [xlen-1:0] i_a,
    input  logic [xlen-1:0] i_b,
    input  logic            i_is_bne,
    output logic [xlen-1:0] o_result,
    output logic            o_branch_taken
);

    logic operands_equal;

    always_comb begin
        case (i_op)
            alu_add:    o_result = i_a + i_b;
            alu_sub:    o_result = i_a - i_b;
            alu_and:    o_result = i_a & i_b;
            alu_or:     o_result = i_a | i_b;
            alu_xor:    o_result = i_a ^ i_b;
            alu_pass_b: o_result = i_b;
            default:    o_result = '0;
        endcase
    end

    // equal when the difference is zero.
    assign operands_equal = (o_result == '0);
    assign o_branch_taken = operands_equal ^ i_is_bne;

endmodule

`default_nettype wire

//--- cpu_control.sv
`default_nettype none

module cpu_control import cpu_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic i_raddr_ready,
    input  logic i_rdata_valid,
    input  logic i_type_int_reg,
    input  logic i_type_branch,
    input  logic i_rd_is_zero,
    output logic o_raddr_valid,
    output logic o_rdata_ready,
    output logic o_inst_load,
    output logic o_rs1_en,
    output logic o_rs2_en,
    output logic o_rd_en,
    output logic o_pc_update
);

    state_t state;
    state_t state_next;
    logic   addr_hs;
    logic   data_hs;

    assign addr_hs = o_raddr_valid & i_raddr_ready;
    assign data_hs = o_rdata_ready & i_rdata_valid;

    always_comb begin
        state_next = state;
        case (state)
            fetch_s: if (addr_hs) state_next = load_s;
            load_s:  if (data_hs) state_next = exec_s;
            exec_s:  state_next = wb_s;
            wb_s:    state_next = fetch_s;
            default: state_next = fetch_s;
        endcase
    end

    // bus valid and ready are registered from the next state.
    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= fetch_s;
            o_raddr_valid <= 1'b0;
            o_rdata_ready <= 1'b0;
        end else begin
            state         <= state_next;
            o_raddr_valid <= (state_next == fetch_s);
            o_rdata_ready <= (state_next == load_s);
        end
    end

    assign o_inst_load = data_hs;
    assign o_rs1_en    = (state == exec_s);
    assign o_rs2_en    = (state == exec_s) & (i_type_int_reg | i_type_branch);

    // branches and x0 targets never write.
    assign o_rd_en     = (state == wb_s) & ~i_type_branch & ~i_rd_is_zero;
    assign o_pc_update = (state == wb_s);

endmodule

`default_nettype wire

//--- cpu_core.sv
`default_nettype none

module cpu_core import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    output logic                  o_raddr_valid,
    output logic [xlen-1:0]       o_raddr,
    input  logic                  i_raddr_ready,
    input  logic                  i_rdata_valid,
    input  logic [xlen-1:0]       i_rdata,
    output logic                  o_rdata_ready,
    output logic                  o_wb_en,
    output logic [reg_addr_w-1:0] o_wb_addr,
    output logic [xlen-1:0]       o_wb_data,
    output logic [xlen-1:0]       o_pc
);

    logic [xlen-1:0]       pc;
    inst_t                 inst;
    logic                  inst_load;
    logic                  pc_update;
    logic                  rs1_en;
    logic                  rs2_en;
    logic                  rd_en;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       imm;
    alu_op_t               alu_op;
    logic                  type_imm;
    logic                  type_int_reg;
    logic                  type_branch;
    logic                  rd_is_zero;
    logic [xlen-1:0]       rs1_dout;
    logic [xlen-1:0]       rs2_dout;
    logic [xlen-1:0]       alu_b;
    logic [xlen-1:0]       alu_result;
    logic                  branch_taken;
    logic                  is_bne;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (pc_update) begin
            if (type_branch && branch_taken) begin
                pc <= pc + imm; // branch target.
            end else begin
                pc <= pc + xlen'(4);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inst_load) begin
            inst <= i_rdata;
        end
    end

    assign o_raddr = pc;
    assign o_pc    = pc;

    assign alu_b  = type_imm ? imm : rs2_dout;
    assign is_bne = (inst.r.funct3 == f3_bne);

    // write-back trace follows the register file write port.
    assign o_wb_en   = rd_en;
    assign o_wb_addr = rd;
    assign o_wb_data = alu_result;

    cpu_control control (
        .clk            (clk),
        .rst            (rst),
        .i_raddr_ready  (i_raddr_ready),
        .i_rdata_valid  (i_rdata_valid),
        .i_type_int_reg (type_int_reg),
        .i_type_branch  (type_branch),
        .i_rd_is_zero   (rd_is_zero),
        .o_raddr_valid  (o_raddr_valid),
        .o_rdata_ready  (o_rdata_ready),
        .o_inst_load    (inst_load),
        .o_rs1_en       (rs1_en),
        .o_rs2_en       (rs2_en),
        .o_rd_en        (rd_en),
        .o_pc_update    (pc_update)
    );

    inst_decoder idec (
        .i_inst         (inst),
        .o_rd           (rd),
        .o_rs1          (rs1),
        .o_rs2          (rs2),
        .o_imm          (imm),
        .o_alu_op       (alu_op),
        .o_type_imm     (type_imm),
        .o_type_int_imm (),
        .o_type_int_reg (type_int_reg),
        .o_type_branch  (type_branch),
        .o_rd_is_zero   (rd_is_zero)
    );

    reg_file rf (
        .clk        (clk),
        .i_rs1_en   (rs1_en),
        .i_rs1      (rs1),
        .o_rs1_dout (rs1_dout),
        .i_rs2_en   (rs2_en),
        .i_rs2      (rs2),
        .o_rs2_dout (rs2_dout),
        .i_rd_en    (rd_en),
        .i_rd       (rd),
        .i_rd_din   (alu_result)
    );

    cpu_alu alu (
        .i_op           (alu_op),
        .i_a            (rs1_dout),
        .i_b            (alu_b),
        .i_is_bne       (is_bne),
        .o_result       (alu_result),
        .o_branch_taken (branch_taken)
    );

endmodule

`default_nettype wire

//--- cpu_monitor_sva.sv
`default_nettype none

module cpu_monitor_sva import cpu_pkg::*; (
    input logic            clk,
    input logic            rst,
    input logic            i_raddr_valid,
    input logic            i_raddr_ready,
    input logic [xlen-1:0] i_raddr,
    input logic            i_rdata_valid,
    input logic            i_rdata_ready,
    input logic            i_wb_en,
    input state_t          i_state
);

    logic data_hs;

    assign data_hs = i_rdata_valid & i_rdata_ready;

    a_raddr_stable: assert property (@(posedge clk) disable iff (rst)
        (i_raddr_valid && !i_raddr_ready) |=> $stable(i_raddr))
        else $error("fetch address moved while waiting for ready");

    a_fetch_next: assert property (@(posedge clk) disable iff (rst)
        (i_state == fetch_s) |=> (i_state == fetch_s || i_state == load_s))
        else $error("illegal transition out of fetch state");

    a_load_next: assert property (@(posedge clk) disable iff (rst)
        (i_state == load_s) |=> (i_state == load_s || i_state == exec_s))
        else $error("illegal transition out of load state");

    a_exec_next: assert property (@(posedge clk) disable iff (rst)
        (i_state == exec_s) |=> (i_state == wb_s))
        else $error("exec state did not move to write-back");

    a_wb_next: assert property (@(posedge clk) disable iff (rst)
        (i_state == wb_s) |=> (i_state == fetch_s))
        else $error("write-back state did not return to fetch");

    // a write-back pulse only ever follows a data handshake by two cycles.
    a_wb_latency: assert property (@(posedge clk) disable iff (rst)
        i_wb_en |-> $past(data_hs, 2))
        else $error("write-back pulse without a data handshake two cycles before");

endmodule

bind cpu_core cpu_monitor_sva monitor_i (
    .clk           (clk),
    .rst           (rst),
    .i_raddr_valid (o_raddr_valid),
    .i_raddr_ready (i_raddr_ready),
    .i_raddr       (o_raddr),
    .i_rdata_valid (i_rdata_valid),
    .i_rdata_ready (o_rdata_ready),
    .i_wb_en       (o_wb_en),
    .i_state       (control.state)
);

`default_nettype wire

//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // major opcodes.
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_branch = 7'b1100011;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;

    localparam logic [6:0] f7_sub = 7'b0100000; // turns add into sub.

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b
    } alu_op_t;

    typedef enum logic [1:0] {
        fetch_s,
        load_s,
        exec_s,
        wb_s
    } state_t;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } inst_i_t;

    // one instruction word, two field layouts.
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_t;

endpackage

`default_nettype wire

//--- inst_decoder.sv
`default_nettype none

module inst_decoder import cpu_pkg::*; (
    input  inst_t                 i_inst,
    output logic [reg_addr_w-1:0] o_rd,
    output logic [reg_addr_w-1:0] o_rs1,
    output logic [reg_addr_w-1:0] o_rs2,
    output logic [xlen-1:0]       o_imm,
    output alu_op_t               o_alu_op,
    output logic                  o_type_imm,
    output logic                  o_type_int_imm,
    output logic                  o_type_int_reg,
    output logic                  o_type_branch,
    output logic                  o_rd_is_zero
);

    logic [6:0]      opcode;
    logic            type_lui;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;

    assign opcode = i_inst.r.opcode;
    assign o_rd   = i_inst.r.rd;
    assign o_rs1  = i_inst.r.rs1;
    assign o_rs2  = i_inst.r.rs2;

    assign o_type_int_imm = (opcode == op_imm);
    assign o_type_int_reg = (opcode == op_reg);
    assign o_type_branch  = (opcode == op_branch);
    assign type_lui       = (opcode == op_lui);
    assign o_type_imm     = o_type_int_imm | type_lui; // immediate feeds alu operand b.
    assign o_rd_is_zero   = (i_inst.r.rd == '0);

    assign imm_i = {{(xlen-12){i_inst.i.imm[11]}}, i_inst.i.imm};
    assign imm_b = {{(xlen-12){i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_u = {i_inst[31:12], 12'b0};

    assign o_imm = o_type_branch ? imm_b : (type_lui ? imm_u : imm_i);

    always_comb begin
        o_alu_op = alu_add;
        if (o_type_int_reg || o_type_int_imm) begin
            case (i_inst.r.funct3)
                f3_add_sub: begin
                    // only the register form has a sub.
                    if (o_type_int_reg && i_inst.r.funct7 == f7_sub) begin
                        o_alu_op = alu_sub;
                    end
                end
                f3_xor:  o_alu_op = alu_xor;
                f3_or:   o_alu_op = alu_or;
                f3_and:  o_alu_op = alu_and;
                default: o_alu_op = alu_add;
            endcase
        end else if (o_type_branch) begin
            o_alu_op = alu_sub; // compare by subtraction.
        end else if (type_lui) begin
            o_alu_op = alu_pass_b;
        end
    end

endmodule

`default_nettype wire

//--- project.f
cpu_pkg.sv
inst_decoder.sv
reg_file.sv
cpu_alu.sv
cpu_control.sv
cpu_core.sv
tb_clock_gen.sv
tb_inst_mem.sv
cpu_monitor_sva.sv
tb_cpu.sv

//--- reg_file.sv
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  i_rs1_en,
    input  logic [reg_addr_w-1:0] i_rs1,
    output logic [xlen-1:0]       o_rs1_dout,
    input  logic                  i_rs2_en,
    input  logic [reg_addr_w-1:0] i_rs2,
    output logic [xlen-1:0]       o_rs2_dout,
    input  logic                  i_rd_en,
    input  logic [reg_addr_w-1:0] i_rd,
    input  logic [xlen-1:0]       i_rd_din
);

    logic [xlen-1:0] regs [0:(1<<reg_addr_w)-1];

    always_ff @(posedge clk) begin
        if (i_rd_en && i_rd != '0) begin
            regs[i_rd] <= i_rd_din;
        end
    end

    // read data shows up the cycle after the enable.
    always_ff @(posedge clk) begin
        if (i_rs1_en) begin
            o_rs1_dout <= (i_rs1 == '0) ? '0 : regs[i_rs1];
        end
        if (i_rs2_en) begin
            o_rs2_dout <= (i_rs2 == '0) ? '0 : regs[i_rs2];
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_cpu -o sim_cpu
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^All checks passed$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk; // period of 10.
    end

    initial begin
        o_rst = 1'b1;
        repeat (3) @(posedge o_clk);
        @(negedge o_clk);
        o_rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- tb_cpu.sv
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

    localparam int run_len   = 40;
    localparam int max_cycle = 16 * run_len + 100;
    localparam int t_imm     = 0;
    localparam int t_reg     = 1;
    localparam int t_branch  = 2;
    localparam int t_stall   = 3;
    localparam int t_reset   = 4;

    logic                  clk;
    logic                  rst;
    logic                  raddr_valid;
    logic [xlen-1:0]       raddr;
    logic                  raddr_ready;
    logic                  rdata_valid;
    logic [xlen-1:0]       rdata;
    logic                  rdata_ready;
    logic                  wb_en;
    logic [reg_addr_w-1:0] wb_addr;
    logic [xlen-1:0]       wb_data;
    logic [xlen-1:0]       pc;
    logic                  addr_hs;
    logic                  data_hs;

    inst_t           prog [0:31];
    logic [xlen-1:0] br_off [0:31]; // branch offsets as written in the program.
    logic [xlen-1:0] mregs [0:31];
    logic [xlen-1:0] exp_pc;
    logic            exp_we;
    logic [4:0]      exp_addr;
    logic [xlen-1:0] exp_data;
    int              wb_test;
    int              fetch_test;
    int              executed;
    int              cycles;
    int              checks [0:4];
    int              fails [0:4];
    logic            prev_rst;

    tb_clock_gen clock_gen_i (.o_clk(clk), .o_rst(rst));

    tb_inst_mem mem_i (
        .clk           (clk),
        .rst           (rst),
        .i_raddr_valid (raddr_valid),
        .i_raddr       (raddr),
        .o_raddr_ready (raddr_ready),
        .o_rdata_valid (rdata_valid),
        .o_rdata       (rdata),
        .i_rdata_ready (rdata_ready)
    );

    cpu_core cpu_core_i (
        .clk           (clk),
        .rst           (rst),
        .o_raddr_valid (raddr_valid),
        .o_raddr       (raddr),
        .i_raddr_ready (raddr_ready),
        .i_rdata_valid (rdata_valid),
        .i_rdata       (rdata),
        .o_rdata_ready (rdata_ready),
        .o_wb_en       (wb_en),
        .o_wb_addr     (wb_addr),
        .o_wb_data     (wb_data),
        .o_pc          (pc)
    );

    assign addr_hs = raddr_valid & raddr_ready;
    assign data_hs = rdata_valid & rdata_ready;

    function automatic string test_name(input int id);
        case (id)
            t_imm:    return "imm_ops";
            t_reg:    return "reg_ops";
            t_branch: return "branches";
            t_stall:  return "stalls";
            default:  return "reset";
        endcase
    endfunction

    function automatic inst_t enc_r(input logic [2:0] f3, input logic [6:0] f7,
                                    input int rd, input int rs1, input int rs2);
        inst_t w;
        w.r = '{f7, 5'(rs2), 5'(rs1), f3, 5'(rd), op_reg};
        return w;
    endfunction

    function automatic inst_t enc_i(input logic [2:0] f3, input int rd, input int rs1,
                                    input logic [11:0] imm);
        inst_t w;
        w.i = '{imm, 5'(rs1), f3, 5'(rd), op_imm};
        return w;
    endfunction

    // b-type offset is scattered over the funct7 and rd fields.
    function automatic inst_t enc_b(input logic [2:0] f3, input int rs1, input int rs2,
                                    input logic [12:0] off);
        inst_t w;
        w.r = '{{off[12], off[10:5]}, 5'(rs2), 5'(rs1), f3, {off[4:1], off[11]}, op_branch};
        return w;
    endfunction

    function automatic inst_t enc_u(input int rd, input logic [19:0] imm);
        inst_t w;
        w = {imm, 5'(rd), op_lui};
        return w;
    endfunction

    task automatic put_branch(input int k, input logic [2:0] f3, input int rs1,
                              input int rs2, input logic [12:0] off);
        prog[k]   = enc_b(f3, rs1, rs2, off);
        br_off[k] = {{19{off[12]}}, off};
    endtask

    initial begin
        void'($urandom(32'h094d_d08e));
        prog[0]  = enc_i(f3_add_sub, 1, 0, 12'h123);
        prog[1]  = enc_i(f3_add_sub, 2, 0, 12'hffb);
        prog[2]  = enc_i(f3_and, 3, 1, 12'h0f0);
        prog[3]  = enc_i(f3_or, 4, 2, 12'h300);
        prog[4]  = enc_i(f3_xor, 5, 1, 12'hfff);
        prog[5]  = enc_u(6, 20'habcde);
        prog[6]  = enc_r(f3_add_sub, 7'd0, 7, 1, 2);
        prog[7]  = enc_r(f3_add_sub, f7_sub, 8, 6, 1);
        prog[8]  = enc_r(f3_and, 7'd0, 9, 4, 5);
        prog[9]  = enc_r(f3_or, 7'd0, 10, 3, 6);
        prog[10] = enc_r(f3_xor, 7'd0, 11, 7, 8);
        prog[11] = enc_r(f3_add_sub, 7'd0, 0, 1, 2);  // x0 target, no pulse.
        prog[12] = enc_r(f3_add_sub, 7'd0, 12, 0, 1);
        put_branch(13, f3_beq, 1, 1, 13'd8);
        prog[14] = enc_i(f3_add_sub, 13, 0, 12'h001);
        put_branch(15, f3_bne, 1, 1, 13'd8);
        put_branch(16, f3_bne, 1, 2, 13'd8);
        prog[17] = enc_i(f3_add_sub, 13, 0, 12'h002);
        put_branch(18, f3_beq, 1, 2, 13'd8);
        prog[19] = enc_r(f3_add_sub, f7_sub, 14, 2, 1);
        prog[20] = enc_i(f3_xor, 15, 14, 12'h555);
        put_branch(21, f3_beq, 0, 0, -13'sd84);   // back to word 0.
        for (int k = 22; k < 32; k++) begin
            prog[k] = enc_i(f3_add_sub, 0, 0, 12'(k * 4));
        end
        for (int k = 0; k < 32; k++) begin
            mem_i.mem[k] = prog[k];
            mregs[k] = '0;
        end
        for (int k = 0; k < 5; k++) begin
            checks[k] = 0;
            fails[k]  = 0;
        end
        wait (executed == run_len);
        do @(negedge clk); while (!raddr_valid);
        @(posedge clk);
        for (int k = 0; k < 5; k++) begin
            $display("test %s: %0d checks, %0d failed", test_name(k), checks[k], fails[k]);
        end
        $display("totals: %0d checks, %0d failed", checks.sum(), fails.sum());
        if (fails.sum() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // stall-free reference, stepped once per fetched instruction.
    always @(posedge clk) begin : model_step
        inst_t           w;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] imm_i;
        logic [xlen-1:0] val;
        logic [xlen-1:0] next;
        logic            we;
        int              test;
        if (rst) begin
            exp_pc     <= '0;
            exp_we     <= 1'b0;
            executed   <= 0;
            fetch_test <= t_reset;
            prev_rst   <= 1'b1;
        end else begin
            prev_rst <= 1'b0;
            if (raddr_valid && !raddr_ready) checks[t_stall]++;
            if (addr_hs) checks[fetch_test]++;
            if (data_hs) begin
                w     = prog[exp_pc[6:2]];
                a     = mregs[w.r.rs1];
                b     = mregs[w.r.rs2];
                imm_i = {{20{w.i.imm[11]}}, w.i.imm};
                val   = '0;
                we    = 1'b1;
                next  = exp_pc + 32'd4;
                test  = t_imm;
                case (w.r.opcode)
                    op_imm: begin
                        case (w.i.funct3)
                            f3_xor:  val = a ^ imm_i;
                            f3_or:   val = a | imm_i;
                            f3_and:  val = a & imm_i;
                            default: val = a + imm_i;
                        endcase
                    end
                    op_reg: begin
                        test = t_reg;
                        case (w.r.funct3)
                            f3_xor:  val = a ^ b;
                            f3_or:   val = a | b;
                            f3_and:  val = a & b;
                            default: val = (w.r.funct7 == f7_sub) ? a - b : a + b;
                        endcase
                    end
                    op_lui: val = {w[31:12], 12'h000};
                    default: begin
                        test = t_branch;
                        we   = 1'b0;
                        if ((a == b) != (w.r.funct3 == f3_bne)) begin
                            next = exp_pc + br_off[exp_pc[6:2]];
                        end
                    end
                endcase
                if (w.r.rd == 5'd0) we = 1'b0;
                if (we) mregs[w.r.rd] = val;
                checks[test]++;
                exp_we     <= we;
                exp_addr   <= w.r.rd;
                exp_data   <= val;
                wb_test    <= test;
                fetch_test <= test;
                exp_pc     <= next;
                executed   <= executed + 1;
            end
        end
        if (rst && prev_rst) checks[t_reset]++;
    end

    always @(posedge clk) begin
        cycles <= rst ? 0 : cycles + 1;
        if (cycles > max_cycle) begin
            $display("timeout: the program did not finish within %0d cycles", max_cycle);
            $display("Checks failed");
            $finish;
        end
    end

    a_wb: assert property (@(posedge clk) disable iff (rst)
        data_hs |-> ##2 (wb_en == exp_we &&
                         (!exp_we || (wb_addr == exp_addr && wb_data == exp_data))))
        else begin
            $display("[FAIL] %s: expected en=%0b x%0d=%h, actual en=%0b x%0d=%h",
                     test_name(wb_test), exp_we, exp_addr, exp_data,
                     $sampled(wb_en), $sampled(wb_addr), $sampled(wb_data));
            fails[wb_test]++;
        end

    a_fetch_addr: assert property (@(posedge clk) disable iff (rst)
        addr_hs |-> (raddr == exp_pc && pc == exp_pc))
        else begin
            $display("[FAIL] %s: expected fetch address and pc %h, actual %h and %h",
                     test_name(fetch_test), exp_pc, $sampled(raddr), $sampled(pc));
            fails[fetch_test]++;
        end

    a_addr_hold: assert property (@(posedge clk) disable iff (rst)
        (raddr_valid && !raddr_ready) |=> $stable(raddr))
        else begin
            $display("[FAIL] %s: expected address %h, actual %h", test_name(t_stall),
                     $past(raddr), $sampled(raddr));
            fails[t_stall]++;
        end

    a_reset_quiet: assert property (@(posedge clk)
        (rst && prev_rst) |-> (!rdata_ready && !wb_en))
        else begin
            $display("reset: data ready or write-back pulse seen while in reset");
            fails[t_reset]++;
        end

endmodule

`default_nettype wire

//--- tb_inst_mem.sv
`default_nettype none

module tb_inst_mem import cpu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            i_raddr_valid,
    input  logic [xlen-1:0] i_raddr,
    output logic            o_raddr_ready,
    output logic            o_rdata_valid,
    output logic [xlen-1:0] o_rdata,
    input  logic            i_rdata_ready
);

    logic [xlen-1:0] mem [0:31];
    logic            pending;
    logic [xlen-1:0] addr;

    // one outstanding address at a time.
    always @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            addr    <= '0;
        end else begin
            if (i_raddr_valid && o_raddr_ready) begin
                pending <= 1'b1;
                addr    <= i_raddr;
            end
            if (o_rdata_valid && i_rdata_ready) begin
                pending <= 1'b0;
            end
        end
    end

    // roughly one cycle in four is a stall.
    initial begin
        o_raddr_ready = 1'b0;
        o_rdata_valid = 1'b0;
        o_rdata       = '0;
        forever begin
            @(negedge clk);
            o_raddr_ready = !pending && ($urandom % 4 != 0);
            o_rdata_valid = pending && ($urandom % 4 != 0);
            o_rdata       = mem[addr[6:2]];
        end
    end

endmodule

`default_nettype wire
